//--- src.f
src/lc3b_isa_pkg.sv
src/lc3b_pipe_pkg.sv
src/lc3b_decode.sv
src/lc3b_execute.sv
src/lc3b_result.sv
src/branch_controller.sv
src/lc3b_core.sv
testbench/lc3b_core_chk.sv
testbench/lc3b_core_tb.sv

//--- Makefile
SIM := obj_dir/Vlc3b_core_tb

.PHONY: all run clean

all: run

$(SIM): src.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module lc3b_core_tb -f src.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/lc3b_core_tb.sv
`timescale 1ns/100ps

module lc3b_core_tb;
    import lc3b_isa_pkg::*;

    localparam lc3b_word RESET_PC   = 16'h0020;
    localparam int       CLK_PERIOD = 100;

    typedef struct packed {
        lc3b_word pc;
        logic     we;
        lc3b_reg  dest;
        lc3b_word data;
    } retire_rec_t;

    logic       clk;
    logic       rst_n;
    lc3b_word   imem_rdata;
    lc3b_word   imem_addr;
    logic       retire_valid;
    lc3b_word   retire_pc;
    logic       retire_we;
    lc3b_reg    retire_dest;
    lc3b_word   retire_data;

    lc3b_word   imem [256];
    int         wp;
    int         prog_len;
    lc3b_word   halt_pc;
    logic       prog_ready = 1'b0;
    int         errors = 0;

    // Architectural state of the reference model.
    lc3b_word   ref_pc;
    lc3b_word   ref_regs [8];
    logic [2:0] ref_cc;

    lc3b_core #(
        .RESET_PC (RESET_PC)
    ) u_lc3b_core (
        .*
    );

    assign imem_rdata = imem[imem_addr[8:1]]; // Same-cycle read.

    bind branch_controller lc3b_core_chk u_core_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_id_valid  (if_id_valid),
        .if_id_opcode (if_id_opcode),
        .ex_wb_valid  (ex_wb_valid),
        .ex_wb_opcode (ex_wb_opcode),
        .pc           (pc),
        .fetch_stall  (fetch_stall),
        .squash_if_id (squash_if_id),
        .squash_id_ex (squash_id_ex),
        .squash_ex_wb (squash_ex_wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Program builder
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic lc3b_word enc_operate(input lc3b_opcode op, input lc3b_reg dr,
                                             input lc3b_reg sr1, input logic imm_flag,
                                             input logic [4:0] low5);
        return {op, dr, sr1, imm_flag, low5};
    endfunction

    function automatic lc3b_word enc_offset(input lc3b_opcode op, input logic [2:0] f3,
                                            input logic [8:0] off9);
        return {op, f3, off9};
    endfunction

    task automatic emit(input lc3b_word word);
        imem[wp] = word;
        wp++;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        lc3b_reg     dr, sr1, sr2;
        logic [4:0]  low5;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'hd, 4'h5, i[7:0]}; // SHF words retire as no-operations.
        end
        wp  = int'(RESET_PC[15:1]);
        rnd = 32'd76542;
        for (int i = 0; i < 32; i++) begin
            rnd  = xorshift32(rnd);
            dr   = {1'b0, rnd[1:0]}; // Four registers keep dependencies close together.
            sr1  = {1'b0, rnd[3:2]};
            sr2  = {1'b0, rnd[5:4]};
            low5 = rnd[13] ? rnd[10:6] : {2'b00, sr2};
            case (rnd[12:11])
                2'd0, 2'd1: emit(enc_operate(op_add, dr, sr1, rnd[13], low5));
                2'd2:       emit(enc_operate(op_and, dr, sr1, rnd[13], low5));
                default:    emit(enc_operate(op_not, dr, sr1, 1'b1, 5'h1f));
            endcase
        end
        // Every nzp mask is tried against Z, N and P with a LEA in between.
        for (int k = 0; k < 3; k++) begin
            for (int m = 0; m < 8; m++) begin
                emit(enc_operate(op_and, 3'd1, 3'd1, 1'b1, 5'd0));
                emit(enc_operate(op_add, 3'd1, 3'd1, 1'b1,
                                 (k == 0) ? 5'd0 : (k == 1) ? 5'h1f : 5'd5));
                emit(enc_offset(op_lea, 3'd4, 9'(m)));
                emit(enc_offset(op_br, 3'(m), 9'd1));
                emit(enc_operate(op_add, 3'd2, 3'd2, 1'b1, 5'd1)); // Skipped when taken.
            end
        end
        emit(enc_offset(op_br, 3'b111, 9'd2));               // Jump over the subroutine.
        emit(enc_operate(op_add, 3'd3, 3'd3, 1'b1, 5'd2));
        emit(enc_operate(op_jmp, 3'd0, 3'd7, 1'b0, 5'd0));   // RET
        emit({op_jsr, 1'b1, 11'h7fd});                       // Back three words to the subroutine.
        emit(enc_offset(op_lea, 3'd5, 9'd2));
        emit(enc_operate(op_jsr, 3'd0, 3'd5, 1'b0, 5'd0));   // JSRR through R5.
        emit(enc_operate(op_add, 3'd2, 3'd2, 1'b1, 5'd1));
        emit(enc_offset(op_lea, 3'd6, 9'd2));
        emit(enc_operate(op_jmp, 3'd0, 3'd6, 1'b0, 5'd0));
        emit(enc_operate(op_add, 3'd2, 3'd2, 1'b1, 5'd1));
        halt_pc = lc3b_word'(wp * 2);
        emit(enc_offset(op_br, 3'b111, 9'h1ff));             // Branches to itself.
        prog_len = wp - int'(RESET_PC[15:1]);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    function automatic retire_rec_t arch_step();
        lc3b_word    ir, a, b, pc2;
        lc3b_opcode  op;
        retire_rec_t rec;
        ir  = imem[ref_pc[8:1]];
        op  = lc3b_opcode'(ir[15:12]);
        a   = ref_regs[ir[8:6]];
        b   = ir[5] ? {{11{ir[4]}}, ir[4:0]} : ref_regs[ir[2:0]];
        pc2 = ref_pc + 16'd2;
        rec = '{pc: ref_pc, we: 1'b0, dest: ir[11:9], data: 16'h0000};
        ref_pc = pc2;
        case (op)
            op_add: rec.data = a + b;
            op_and: rec.data = a & b;
            op_not: rec.data = ~a;
            op_lea: rec.data = pc2 + {{6{ir[8]}}, ir[8:0], 1'b0};
            op_br:  if (|(ir[11:9] & ref_cc)) ref_pc = pc2 + {{6{ir[8]}}, ir[8:0], 1'b0};
            op_jmp: ref_pc = a;
            op_jsr: begin
                rec.dest = 3'd7;
                rec.data = pc2;
                ref_pc   = ir[11] ? pc2 + {{4{ir[10]}}, ir[10:0], 1'b0} : a;
            end
            default: ;
        endcase
        rec.we = op inside {op_add, op_and, op_not, op_lea, op_jsr};
        if (op inside {op_add, op_and, op_not}) begin
            if ($signed(rec.data) < 0) begin
                ref_cc = 3'b100;
            end else if (rec.data == 16'h0000) begin
                ref_cc = 3'b010;
            end else begin
                ref_cc = 3'b001;
            end
        end
        if (rec.we) begin
            ref_regs[rec.dest] = rec.data;
        end
        return rec;
    endfunction

    task automatic check_value(input string what, input lc3b_word got, input lc3b_word want);
        if (got !== want) begin
            errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial begin : stimulus
        rst_n = 1'b0;
        build_program();
        ref_pc = RESET_PC;
        ref_cc = 3'b010;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        prog_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        check_value("retire_valid in reset", 16'(retire_valid), 16'h0000);
        check_value("imem_addr in reset", imem_addr, RESET_PC);
        rst_n = 1'b1;
    end

    initial begin : compare_retire
        retire_rec_t want;
        logic        halted;
        halted = 1'b0;
        wait (prog_ready);
        while (!halted) begin
            @(negedge clk);
            if (rst_n && retire_valid) begin
                want = arch_step();
                check_value("retire_pc", retire_pc, want.pc);
                check_value("retire_we", 16'(retire_we), 16'(want.we));
                if (want.we) begin
                    check_value("retire_dest", 16'(retire_dest), 16'(want.dest));
                    check_value("retire_data", retire_data, want.data);
                end
                halted = (want.pc == halt_pc);
            end
        end
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (prog_ready);
        #((prog_len * 4 + 40) * CLK_PERIOD); // Four cycles per instruction at worst.
        $display("Timeout: the halt loop was not reached in %0d cycles", prog_len * 4 + 40);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule : lc3b_core_tb

//--- testbench/lc3b_core_chk.sv
`timescale 1ns/100ps

module lc3b_core_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     if_id_valid,
    input lc3b_isa_pkg::lc3b_opcode if_id_opcode,
    input logic                     ex_wb_valid,
    input lc3b_isa_pkg::lc3b_opcode ex_wb_opcode,
    input lc3b_isa_pkg::lc3b_word   pc,
    input logic                     fetch_stall,
    input logic                     squash_if_id,
    input logic                     squash_id_ex,
    input logic                     squash_ex_wb
);
    import lc3b_isa_pkg::*;

    logic if_id_redirects, wb_redirects;

    // BR, JMP and JSR change the PC.
    assign if_id_redirects = if_id_valid && (if_id_opcode inside {op_br, op_jmp, op_jsr});
    assign wb_redirects    = ex_wb_valid && (ex_wb_opcode inside {op_br, op_jmp, op_jsr});

    squash_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(squash_if_id || squash_id_ex || squash_ex_wb))
        else $error("a squash level is high during reset");

    stall_on_decode_branch: assert property (@(posedge clk) disable iff (!rst_n)
        if_id_redirects |-> fetch_stall)
        else $error("fetch not stalled with a PC-changing opcode in IF/ID");

    pc_holds_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_stall && !wb_redirects) |=> (pc == $past(pc)))
        else $error("PC moved during a stall without a writeback redirect");

endmodule : lc3b_core_chk

//--- src/lc3b_core.sv
`timescale 1ns/100ps

module lc3b_core #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lc3b_isa_pkg::lc3b_word imem_rdata,
    output lc3b_isa_pkg::lc3b_word imem_addr,
    output logic                   retire_valid,
    output lc3b_isa_pkg::lc3b_word retire_pc,
    output logic                   retire_we,
    output lc3b_isa_pkg::lc3b_reg  retire_dest,
    output lc3b_isa_pkg::lc3b_word retire_data
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    // Pipeline control.
    logic       fetch_stall, squash_if_id, squash_id_ex, squash_ex_wb;
    logic       br_en;

    // IF/ID and ID/EX barriers.
    logic       if_id_valid, id_ex_valid;
    lc3b_opcode if_id_opcode, id_ex_opcode;
    lc3b_word   id_ex_pc, id_ex_a, id_ex_b, id_ex_imm, id_ex_offset;
    lc3b_alu_op id_ex_alu_op;
    lc3b_reg    id_ex_src1, id_ex_src2, id_ex_dest;
    logic       id_ex_use_imm, id_ex_we, id_ex_set_cc;
    logic [2:0] id_ex_nzp;

    // EX/WB barrier.
    logic       ex_wb_valid, ex_wb_we, ex_wb_set_cc;
    lc3b_opcode ex_wb_opcode;
    lc3b_word   ex_wb_pc, ex_wb_result, ex_wb_target;
    lc3b_reg    ex_wb_dest;
    logic [2:0] ex_wb_nzp;

    // Register file ports.
    lc3b_reg    rd1_addr, rd2_addr, wb_dest;
    lc3b_word   rd1_data, rd2_data, wb_data;
    logic       wb_we;

    lc3b_decode u_decode (
        .fetch_pc (imem_addr),
        .*
    );

    lc3b_execute u_execute (
        .*
    );

    lc3b_result u_result (
        .*
    );

    branch_controller #(
        .RESET_PC (RESET_PC)
    ) u_branch_controller (
        .pc (imem_addr),
        .*
    );

endmodule : lc3b_core

//--- src/branch_controller.sv
`timescale 1ns/100ps

module branch_controller #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     if_id_valid,
    input  lc3b_isa_pkg::lc3b_opcode if_id_opcode,
    input  logic                     id_ex_valid,
    input  lc3b_isa_pkg::lc3b_opcode id_ex_opcode,
    input  logic                     ex_wb_valid,
    input  lc3b_isa_pkg::lc3b_opcode ex_wb_opcode,
    input  lc3b_isa_pkg::lc3b_word   ex_wb_pc,
    input  lc3b_isa_pkg::lc3b_word   ex_wb_target,
    input  logic                     br_en,
    output lc3b_isa_pkg::lc3b_word   pc,
    output logic                     fetch_stall,
    output logic                     squash_if_id,
    output logic                     squash_id_ex,
    output logic                     squash_ex_wb
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_pc_mux_sel pc_mux_sel;
    lc3b_word       pc_base, pc_plus2, pc_next;
    logic           if_id_changes_pc, id_ex_changes_pc, wb_redirect;

    function automatic logic changes_pc(input lc3b_opcode opcode);
        return (opcode == op_br) || (opcode == op_jmp) || (opcode == op_jsr);
    endfunction

    assign if_id_changes_pc = if_id_valid && changes_pc(if_id_opcode);
    assign id_ex_changes_pc = id_ex_valid && changes_pc(id_ex_opcode);
    assign wb_redirect      = ex_wb_valid && changes_pc(ex_wb_opcode);

    ////////////////////////////////////////////////////////////
    // Stall and squash requests with the oldest barrier last
    always_comb begin
        fetch_stall  = 1'b0;
        squash_if_id = 1'b0;
        squash_id_ex = 1'b0;
        squash_ex_wb = 1'b0;
        if (if_id_changes_pc) begin
            fetch_stall  = 1'b1;
            squash_if_id = 1'b1;
        end
        if (id_ex_changes_pc) begin
            fetch_stall  = 1'b1;
            squash_if_id = 1'b1;
            squash_id_ex = 1'b1;
        end
        if (wb_redirect) begin
            fetch_stall  = 1'b1;
            squash_if_id = 1'b1;
            squash_id_ex = 1'b1;
            squash_ex_wb = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Program counter
    assign pc_mux_sel = (wb_redirect && br_en) ? pc_sel_target : pc_sel_plus2;
    assign pc_base    = wb_redirect ? ex_wb_pc : pc; // A not-taken branch resumes after itself.
    assign pc_plus2   = pc_base + 16'd2;

    always_comb begin
        case (pc_mux_sel)
            pc_sel_target: pc_next = ex_wb_target;
            default:       pc_next = pc_plus2;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (wb_redirect || !fetch_stall) begin
            pc <= pc_next;
        end
    end

endmodule : branch_controller

//--- src/lc3b_result.sv
`timescale 1ns/100ps

module lc3b_result (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ex_wb_valid,
    input  lc3b_isa_pkg::lc3b_opcode ex_wb_opcode,
    input  lc3b_isa_pkg::lc3b_word   ex_wb_pc,
    input  lc3b_isa_pkg::lc3b_word   ex_wb_result,
    input  lc3b_isa_pkg::lc3b_word   ex_wb_target,
    input  lc3b_isa_pkg::lc3b_reg    ex_wb_dest,
    input  logic                     ex_wb_we,
    input  logic                     ex_wb_set_cc,
    input  logic [2:0]               ex_wb_nzp,
    input  lc3b_isa_pkg::lc3b_reg    rd1_addr,
    input  lc3b_isa_pkg::lc3b_reg    rd2_addr,
    output lc3b_isa_pkg::lc3b_word   rd1_data,
    output lc3b_isa_pkg::lc3b_word   rd2_data,
    output logic                     wb_we,
    output lc3b_isa_pkg::lc3b_reg    wb_dest,
    output lc3b_isa_pkg::lc3b_word   wb_data,
    output logic                     br_en,
    output logic                     retire_valid,
    output lc3b_isa_pkg::lc3b_word   retire_pc,
    output logic                     retire_we,
    output lc3b_isa_pkg::lc3b_reg    retire_dest,
    output lc3b_isa_pkg::lc3b_word   retire_data
);
    import lc3b_isa_pkg::*;

    lc3b_word   regs [8];
    logic [2:0] cc; // Held as {n, z, p}.

    assign rd1_data = regs[rd1_addr];
    assign rd2_data = regs[rd2_addr];

    assign wb_we   = ex_wb_valid && ex_wb_we;
    assign wb_dest = ex_wb_dest;
    assign wb_data = (ex_wb_opcode == op_lea) ? ex_wb_target : ex_wb_result; // LEA writes its address.

    // Architectural state starts at zero registers with Z set.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            cc <= 3'b010;
        end else begin
            if (wb_we) begin
                regs[wb_dest] <= wb_data;
            end
            if (ex_wb_valid && ex_wb_set_cc) begin
                cc <= {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};
            end
        end
    end

    always_comb begin
        case (ex_wb_opcode)
            op_br:          br_en = |(ex_wb_nzp & cc);
            op_jmp, op_jsr: br_en = 1'b1;
            default:        br_en = 1'b0;
        endcase
    end

    assign retire_valid = ex_wb_valid;
    assign retire_pc    = ex_wb_pc;
    assign retire_we    = wb_we;
    assign retire_dest  = wb_dest;
    assign retire_data  = wb_data;

endmodule : lc3b_result

//--- src/lc3b_execute.sv
`timescale 1ns/100ps

module lc3b_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      squash_ex_wb,
    input  logic                      id_ex_valid,
    input  lc3b_isa_pkg::lc3b_opcode  id_ex_opcode,
    input  lc3b_isa_pkg::lc3b_word    id_ex_pc,
    input  lc3b_pipe_pkg::lc3b_alu_op id_ex_alu_op,
    input  lc3b_isa_pkg::lc3b_reg     id_ex_src1,
    input  lc3b_isa_pkg::lc3b_reg     id_ex_src2,
    input  lc3b_isa_pkg::lc3b_word    id_ex_a,
    input  lc3b_isa_pkg::lc3b_word    id_ex_b,
    input  logic                      id_ex_use_imm,
    input  lc3b_isa_pkg::lc3b_word    id_ex_imm,
    input  lc3b_isa_pkg::lc3b_word    id_ex_offset,
    input  lc3b_isa_pkg::lc3b_reg     id_ex_dest,
    input  logic                      id_ex_we,
    input  logic                      id_ex_set_cc,
    input  logic [2:0]                id_ex_nzp,
    input  logic                      wb_we,
    input  lc3b_isa_pkg::lc3b_reg     wb_dest,
    input  lc3b_isa_pkg::lc3b_word    wb_data,
    output logic                      ex_wb_valid,
    output lc3b_isa_pkg::lc3b_opcode  ex_wb_opcode,
    output lc3b_isa_pkg::lc3b_word    ex_wb_pc,
    output lc3b_isa_pkg::lc3b_word    ex_wb_result,
    output lc3b_isa_pkg::lc3b_word    ex_wb_target,
    output lc3b_isa_pkg::lc3b_reg     ex_wb_dest,
    output logic                      ex_wb_we,
    output logic                      ex_wb_set_cc,
    output logic [2:0]                ex_wb_nzp
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_word a_fwd, b_fwd, b_op;
    lc3b_word pc_plus2, target, alu_out;

    // The instruction retiring now is the one directly ahead of this one.
    assign a_fwd = (wb_we && wb_dest == id_ex_src1) ? wb_data : id_ex_a;
    assign b_fwd = (wb_we && wb_dest == id_ex_src2) ? wb_data : id_ex_b;
    assign b_op  = id_ex_use_imm ? id_ex_imm : b_fwd;

    assign pc_plus2 = id_ex_pc + 16'd2;
    assign target   = id_ex_use_imm ? pc_plus2 + {id_ex_offset[14:0], 1'b0} : a_fwd;

    always_comb begin
        case (id_ex_alu_op)
            alu_add: alu_out = a_fwd + b_op;
            alu_and: alu_out = a_fwd & b_op;
            alu_not: alu_out = ~a_fwd;
            default: alu_out = pc_plus2; // Link value for JSR and JSRR.
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/WB barrier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb_valid <= 1'b0;
        end else begin
            ex_wb_valid <= id_ex_valid && !squash_ex_wb;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb_opcode <= id_ex_opcode;
        ex_wb_pc     <= id_ex_pc;
        ex_wb_result <= alu_out;
        ex_wb_target <= target;
        ex_wb_dest   <= id_ex_dest;
        ex_wb_we     <= id_ex_we;
        ex_wb_set_cc <= id_ex_set_cc;
        ex_wb_nzp    <= id_ex_nzp;
    end

endmodule : lc3b_execute

//--- src/lc3b_decode.sv
`timescale 1ns/100ps

module lc3b_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lc3b_isa_pkg::lc3b_word    imem_rdata,
    input  lc3b_isa_pkg::lc3b_word    fetch_pc,
    input  logic                      fetch_stall,
    input  logic                      squash_if_id,
    input  logic                      squash_id_ex,
    input  logic                      wb_we,
    input  lc3b_isa_pkg::lc3b_reg     wb_dest,
    input  lc3b_isa_pkg::lc3b_word    wb_data,
    input  lc3b_isa_pkg::lc3b_word    rd1_data,
    input  lc3b_isa_pkg::lc3b_word    rd2_data,
    output lc3b_isa_pkg::lc3b_reg     rd1_addr,
    output lc3b_isa_pkg::lc3b_reg     rd2_addr,
    output logic                      if_id_valid,
    output lc3b_isa_pkg::lc3b_opcode  if_id_opcode,
    output logic                      id_ex_valid,
    output lc3b_isa_pkg::lc3b_opcode  id_ex_opcode,
    output lc3b_isa_pkg::lc3b_word    id_ex_pc,
    output lc3b_pipe_pkg::lc3b_alu_op id_ex_alu_op,
    output lc3b_isa_pkg::lc3b_reg     id_ex_src1,
    output lc3b_isa_pkg::lc3b_reg     id_ex_src2,
    output lc3b_isa_pkg::lc3b_word    id_ex_a,
    output lc3b_isa_pkg::lc3b_word    id_ex_b,
    output logic                      id_ex_use_imm,
    output lc3b_isa_pkg::lc3b_word    id_ex_imm,
    output lc3b_isa_pkg::lc3b_word    id_ex_offset,
    output lc3b_isa_pkg::lc3b_reg     id_ex_dest,
    output logic                      id_ex_we,
    output logic                      id_ex_set_cc,
    output logic [2:0]                id_ex_nzp
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_instr_u if_id_word;
    lc3b_word    if_id_pc;
    lc3b_word    imm5_sext, off9_sext, off11_sext;
    lc3b_word    a_read, b_read;
    lc3b_alu_op  alu_op;
    lc3b_reg     dest;
    lc3b_word    offset;
    logic        we, set_cc, use_imm;

    ////////////////////////////////////////////////////////////
    // IF/ID barrier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_valid <= 1'b0;
        end else if (squash_if_id) begin
            if_id_valid <= 1'b0;
        end else if (!fetch_stall) begin
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch_stall) begin
            if_id_word <= imem_rdata;
            if_id_pc   <= fetch_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Field extraction and control
    assign if_id_opcode = if_id_word.operate.opcode;
    assign rd1_addr     = if_id_word.operate.src1; // Also the JMP and JSRR base.
    assign rd2_addr     = if_id_word.operate.low5[2:0];
    assign imm5_sext    = {{11{if_id_word.operate.low5[4]}}, if_id_word.operate.low5};
    assign off9_sext    = {{7{if_id_word.offset.off9[8]}}, if_id_word.offset.off9};
    assign off11_sext   = {{5{if_id_word[10]}}, if_id_word[10:0]};

    // A register written back in this cycle is not yet visible in the file.
    assign a_read = (wb_we && wb_dest == rd1_addr) ? wb_data : rd1_data;
    assign b_read = (wb_we && wb_dest == rd2_addr) ? wb_data : rd2_data;

    // For control transfers use_imm selects a PC-relative target over a base register.
    always_comb begin
        alu_op  = alu_pass;
        dest    = if_id_word.operate.dest;
        offset  = off9_sext;
        use_imm = if_id_word.operate.imm_flag;
        we      = 1'b0;
        set_cc  = 1'b0;
        case (if_id_opcode)
            op_add, op_and: begin
                alu_op = (if_id_opcode == op_add) ? alu_add : alu_and;
                we     = 1'b1;
                set_cc = 1'b1;
            end
            op_not: begin
                alu_op = alu_not;
                we     = 1'b1;
                set_cc = 1'b1;
            end
            op_br, op_lea: begin
                use_imm = 1'b1;
                we      = (if_id_opcode == op_lea);
            end
            op_jmp: use_imm = 1'b0;
            op_jsr: begin
                dest    = 3'd7;
                offset  = off11_sext;
                use_imm = if_id_word[11];
                we      = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ID/EX barrier
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= if_id_valid && !squash_id_ex;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_opcode  <= if_id_opcode;
        id_ex_pc      <= if_id_pc;
        id_ex_alu_op  <= alu_op;
        id_ex_src1    <= rd1_addr;
        id_ex_src2    <= rd2_addr;
        id_ex_a       <= a_read;
        id_ex_b       <= b_read;
        id_ex_use_imm <= use_imm;
        id_ex_imm     <= imm5_sext;
        id_ex_offset  <= offset;
        id_ex_dest    <= dest;
        id_ex_we      <= we;
        id_ex_set_cc  <= set_cc;
        id_ex_nzp     <= if_id_word.offset.nzp;
    end

endmodule : lc3b_decode

//--- src/lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

    // Source of the next PC when a PC-changing instruction reaches writeback.
    typedef enum logic {
        pc_sel_plus2  = 1'b0,
        pc_sel_target = 1'b1
    } lc3b_pc_mux_sel;

    // Operation performed by the execute stage.
    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11 // Passes the link value PC+2.
    } lc3b_alu_op;

endpackage : lc3b_pipe_pkg

//--- src/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // ADD, AND and NOT layout. The low field is SR2 or imm5.
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       imm_flag;
        logic [4:0] low5;
    } lc3b_operate_fmt;

    // BR and LEA layout. The 3-bit field is nzp for BR and DR for LEA.
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] nzp;
        logic [8:0] off9;
    } lc3b_offset_fmt;

    typedef union packed {
        lc3b_operate_fmt operate;
        lc3b_offset_fmt  offset;
    } lc3b_instr_u;

endpackage : lc3b_isa_pkg
